// ==== tb.f ====
+incdir+hw
hw/core_pkg.sv
hw/rob_pkg.sv
hw/rob_fifo.sv
hw/rob.sv
hw/arch_regfile.sv
hw/rob_subsystem_top.sv
verification/rob_checker.sv
verification/rob_tb.sv

// ==== Bender.yml ====
package:
  name: rob_subsystem

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/core_pkg.sv
      - hw/rob_pkg.sv
      - hw/rob_fifo.sv
      - hw/rob.sv
      - hw/arch_regfile.sv
      - hw/rob_subsystem_top.sv

  - target: simulation
    include_dirs:
      - hw
    files:
      - verification/rob_checker.sv
      - verification/rob_tb.sv

// ==== verification/rob_tb.sv ====
`timescale 1ns/1ps

`include "rob_params.svh"

module rob_tb import core_pkg::*, rob_pkg::*; ();

    logic      clk_i;
    logic      reset_i;
    alloc_t    alloc_i;
    rob_idx_t  rob_idx_o;
    logic      alloc_credit_o;
    wb_t       wb_alu_i;
    wb_t       wb_lsu_i;
    wb_t       wb_mul_i;
    logic      retire_credit_i;
    commit_t   commit_o;
    logic      empty_o;
    reg_addr_t arch_rd_addr_i;
    word_t     arch_rd_data_o;

    // Reference model with expected records by slot, program order and shadow registers
    commit_t  exp_rec [`ROB_DEPTH];
    bit       done_flag [`ROB_DEPTH];
    // Step in which each slot was written back
    int       done_at [`ROB_DEPTH];
    rob_idx_t order_q [$];
    // Allocated but not yet written back
    rob_idx_t pend_q [$];
    word_t    shadow [`REG_COUNT];
    rob_idx_t model_tail;
    int       disp_credits;
    int       returned;
    int       commits;
    int       granted;
    int       owed;
    int       last_alloc;
    int       wait_cnt;
    // Commit credits the buffer holds after the last edge
    int       model_credits;
    int       cyc;
    // Retirement predicted for the last edge and its slot
    bit       exp_commit;
    rob_idx_t exp_idx;

    rob_subsystem_top UUT (.*);

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("STATUS: FAIL");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic compare_commit(input commit_t got, input commit_t exp);
        if (got !== exp) begin
            abort_run($sformatf("ERR @%0t commit idx %0d: got pc %h inst %h prd %0d val %h, %s",
                $time, exp.rob_idx, got.pc, got.inst, got.prd, got.value,
                $sformatf("expected pc %h inst %h prd %0d val %h",
                    exp.pc, exp.inst, exp.prd, exp.value)));
        end
    endtask

    task automatic compare_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("ERR @%0t %s: got %h expected %h", $time, what, got, exp));
        end
    endtask

    task automatic compare_idx(input rob_idx_t got, input rob_idx_t exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("ERR @%0t %s: got %0d expected %0d", $time, what, got, exp));
        end
    endtask

    task automatic compare_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("ERR @%0t %s: got %b expected %b", $time, what, got, exp));
        end
    endtask

    // Check outputs at negedge and drive the next stimulus on the rising edge
    task automatic step(input int alloc_pct, input int wb_pct, input bit withhold);
        int        k;
        rob_idx_t  idx;
        rob_idx_t  head;
        alloc_t    a;
        wb_t       w [NUM_WB];
        logic      credit;
        reg_addr_t rd;
        @(negedge clk_i);
        // Shadow holds the commits that reached the register file by the last edge
        compare_word(arch_rd_data_o, shadow[arch_rd_addr_i], "register read");
        compare_bit(commit_o.valid, exp_commit, "commit valid");
        compare_bit(alloc_credit_o, exp_commit, "allocation credit return");
        // Allocation driven last edge is not yet seen by the buffer
        compare_bit(empty_o, logic'(order_q.size() == last_alloc), "empty flag");
        compare_idx(rob_idx_o, model_tail - rob_idx_t'(last_alloc), "tail index");
        rd = reg_addr_t'($urandom % `REG_COUNT);
        if (exp_commit) begin
            compare_commit(commit_o, exp_rec[exp_idx]);
            commits++;
            owed++;
            if (exp_rec[exp_idx].prd != '0) begin
                shadow[exp_rec[exp_idx].prd] = exp_rec[exp_idx].value;
            end
            // Read back the fresh commit next cycle
            rd = exp_rec[exp_idx].prd;
        end
        if (alloc_credit_o) begin
            disp_credits++;
            returned++;
        end
        // Head written back two edges ago and a held credit retire on the coming edge
        exp_commit = 1'b0;
        if (order_q.size() > 0) begin
            head = order_q[0];
            if (done_flag[head] && (cyc - done_at[head]) >= 2 && model_credits > 0) begin
                exp_commit = 1'b1;
                exp_idx = order_q.pop_front();
            end
        end
        // Credit driven last edge is counted on the coming edge
        model_credits = model_credits + int'(retire_credit_i) - int'(exp_commit);
        // Writebacks first, so this cycle's allocation is never a target
        for (int p = 0; p < NUM_WB; p++) begin
            w[p] = '0;
            if (pend_q.size() > 0 && ($urandom % 100) < wb_pct) begin
                k = $urandom % pend_q.size();
                idx = pend_q[k];
                pend_q.delete(k);
                w[p].valid   = 1'b1;
                w[p].rob_idx = idx;
                w[p].value   = $urandom;
                exp_rec[idx].value = w[p].value;
                done_flag[idx] = 1'b1;
                done_at[idx] = cyc;
            end
        end
        a = '0;
        last_alloc = 0;
        if (disp_credits > 0 && ($urandom % 100) < alloc_pct) begin
            a.valid = 1'b1;
            a.pc    = $urandom & 32'hffff_fffc;
            a.inst  = $urandom;
            a.prd   = reg_addr_t'($urandom % `REG_COUNT);
            exp_rec[model_tail] = '{valid: 1'b1, rob_idx: model_tail, pc: a.pc,
                                    inst: a.inst, prd: a.prd, value: '0};
            done_flag[model_tail] = 1'b0;
            order_q.push_back(model_tail);
            pend_q.push_back(model_tail);
            model_tail++;
            disp_credits--;
            last_alloc = 1;
        end
        // Consumer hands back earned credits unless withholding
        credit = 1'b0;
        if (!withhold && owed > 0 && ($urandom % 3) == 0) begin
            credit = 1'b1;
            owed--;
            granted++;
        end
        cyc++;
        @(posedge clk_i);
        alloc_i         <= a;
        wb_alu_i        <= w[WB_ALU];
        wb_lsu_i        <= w[WB_LSU];
        wb_mul_i        <= w[WB_MUL];
        retire_credit_i <= credit;
        arch_rd_addr_i  <= rd;
    endtask

    task automatic drain(input string phase);
        wait_cnt = 0;
        while (order_q.size() > 0) begin
            step(0, 60, 1'b0);
            wait_cnt++;
            if (wait_cnt > 2000) begin
                abort_run({"Timeout while draining the buffer after ", phase});
            end
        end
        // Last commit shows up next cycle and its register read the cycle after
        repeat (2) step(0, 0, 1'b0);
    endtask

    initial begin
        void'($urandom(32'h87f0));
        reset_i         = 1'b1;
        alloc_i         = '0;
        wb_alu_i        = '0;
        wb_lsu_i        = '0;
        wb_mul_i        = '0;
        retire_credit_i = 1'b0;
        arch_rd_addr_i  = '0;
        model_tail    = '0;
        disp_credits  = `ROB_DEPTH;
        returned      = 0;
        commits       = 0;
        granted       = `ROB_COMMIT_CREDITS;
        owed          = 0;
        last_alloc    = 0;
        model_credits = `ROB_COMMIT_CREDITS;
        cyc           = 0;
        exp_commit    = 1'b0;
        exp_idx       = '0;
        for (int r = 0; r < `REG_COUNT; r++) begin
            shadow[r] = '0;
        end
        repeat (4) @(posedge clk_i);
        reset_i <= 1'b0;

        // Idle state after reset with every register reading zero
        @(negedge clk_i);
        compare_bit(commit_o.valid, 1'b0, "commit valid after reset");
        compare_bit(alloc_credit_o, 1'b0, "allocation credit after reset");
        compare_bit(empty_o, 1'b1, "empty after reset");
        for (int r = 0; r < `REG_COUNT; r++) begin
            @(posedge clk_i);
            arch_rd_addr_i <= reg_addr_t'(r);
            @(negedge clk_i);
            compare_word(arch_rd_data_o, '0, "register after reset");
        end

        // Fill every entry without writebacks so dispatch stalls on zero credits
        wait_cnt = 0;
        while (disp_credits > 0) begin
            step(100, 0, 1'b0);
            wait_cnt++;
            if (wait_cnt > 4 * `ROB_DEPTH) begin
                abort_run("Timeout while filling the buffer");
            end
        end
        repeat (8) step(100, 0, 1'b0);
        if (order_q.size() != `ROB_DEPTH || returned != 0) begin
            abort_run("Dispatch did not stall exactly at a full buffer");
        end

        // Complete everything out of order while retire credits are held back
        for (int c = 0; c < 120; c++) begin
            step(0, 60, 1'b1);
        end
        if (commits != granted) begin
            abort_run("Waiting entries did not use every granted commit credit");
        end
        drain("the fill phase");

        // Mixed random traffic with withholding windows
        for (int c = 0; c < 1500; c++) begin
            step(70, 40, ((c / 100) % 3) == 2);
        end
        drain("random traffic");

        if (returned != commits || commits < `ROB_DEPTH) begin
            abort_run("Returned allocation credits do not match the commits");
        end
        $display("STATUS: PASS");
        $finish;
    end

endmodule

// ==== verification/rob_checker.sv ====
`timescale 1ns/1ps

`include "rob_params.svh"

// Protocol rules bound into the reorder buffer
module rob_checker import core_pkg::*, rob_pkg::*; (
    input logic         clk_i,
    input logic         reset_i,
    input logic         alloc_valid_i,
    // Slot the next allocation lands in
    input entry_state_e tail_state_i,
    input wb_t          wb_alu_i,
    input wb_t          wb_lsu_i,
    input wb_t          wb_mul_i,
    // State of each writeback target slot
    input entry_state_e alu_state_i,
    input entry_state_e lsu_state_i,
    input entry_state_e mul_state_i,
    input logic         retire_credit_i,
    input logic         commit_valid_i
);

    // Commit credits granted so far less the commits already seen
    int credits_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            credits_q <= `ROB_COMMIT_CREDITS;
        end else begin
            credits_q <= credits_q + int'(retire_credit_i) - int'(commit_valid_i);
        end
    end

    // Occupancy is contiguous so an occupied tail means every entry is BUSY or DONE
    a_alloc_not_full: assert property (@(posedge clk_i) disable iff (reset_i)
        alloc_valid_i |-> tail_state_i == ENTRY_FREE)
        else $error("allocation while every entry is occupied");

    a_wb_not_free: assert property (@(posedge clk_i) disable iff (reset_i)
        (wb_alu_i.valid -> alu_state_i != ENTRY_FREE) &&
        (wb_lsu_i.valid -> lsu_state_i != ENTRY_FREE) &&
        (wb_mul_i.valid -> mul_state_i != ENTRY_FREE))
        else $error("writeback to a free entry");

    // Commit record is registered so a credit arriving on the retire edge was not yet held
    a_commit_credit: assert property (@(posedge clk_i) disable iff (reset_i)
        commit_valid_i |-> credits_q > int'($past(retire_credit_i)))
        else $error("commit without a held commit credit");

    a_wb_distinct: assert property (@(posedge clk_i) disable iff (reset_i)
        !(wb_alu_i.valid && wb_lsu_i.valid && wb_alu_i.rob_idx == wb_lsu_i.rob_idx) &&
        !(wb_alu_i.valid && wb_mul_i.valid && wb_alu_i.rob_idx == wb_mul_i.rob_idx) &&
        !(wb_lsu_i.valid && wb_mul_i.valid && wb_lsu_i.rob_idx == wb_mul_i.rob_idx))
        else $error("two writeback ports name the same entry");

endmodule

bind rob rob_checker u_rob_checker (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .alloc_valid_i   (alloc_i.valid),
    .tail_state_i    (state_q[tail_q]),
    .wb_alu_i        (wb_alu_i),
    .wb_lsu_i        (wb_lsu_i),
    .wb_mul_i        (wb_mul_i),
    .alu_state_i     (state_q[wb_alu_i.rob_idx]),
    .lsu_state_i     (state_q[wb_lsu_i.rob_idx]),
    .mul_state_i     (state_q[wb_mul_i.rob_idx]),
    .retire_credit_i (retire_credit_i),
    .commit_valid_i  (commit_o.valid)
);

// ==== hw/rob_subsystem_top.sv ====
`timescale 1ns/1ps

// Reorder buffer plus the register file its retirements update
module rob_subsystem_top import core_pkg::*, rob_pkg::*; (
    input  logic      clk_i,
    input  logic      reset_i,
    // Dispatch
    input  alloc_t    alloc_i,
    output rob_idx_t  rob_idx_o,
    output logic      alloc_credit_o,
    // Unit writebacks
    input  wb_t       wb_alu_i,
    input  wb_t       wb_lsu_i,
    input  wb_t       wb_mul_i,
    // Retire consumer
    input  logic      retire_credit_i,
    output commit_t   commit_o,
    output logic      empty_o,
    // Committed state read
    input  reg_addr_t arch_rd_addr_i,
    output word_t     arch_rd_data_o
);

    // Commit stream shared by the outside and the register file
    commit_t commit;

    rob u_rob (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .alloc_i         (alloc_i),
        .rob_idx_o       (rob_idx_o),
        .alloc_credit_o  (alloc_credit_o),
        .wb_alu_i        (wb_alu_i),
        .wb_lsu_i        (wb_lsu_i),
        .wb_mul_i        (wb_mul_i),
        .retire_credit_i (retire_credit_i),
        .commit_o        (commit),
        .empty_o         (empty_o)
    );

    arch_regfile u_arch_regfile (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .commit_i  (commit),
        .rd_addr_i (arch_rd_addr_i),
        .rd_data_o (arch_rd_data_o)
    );

    assign commit_o = commit;

endmodule

// ==== hw/arch_regfile.sv ====
`timescale 1ns/1ps

`include "rob_params.svh"

// Committed register state of the core
module arch_regfile import core_pkg::*, rob_pkg::*; (
    input  logic      clk_i,
    input  logic      reset_i,
    // Retirement stream from the buffer
    input  commit_t   commit_i,
    // Read port for the outside
    input  reg_addr_t rd_addr_i,
    output word_t     rd_data_o
);

    word_t regs_q [`REG_COUNT];

    // Writes to x0 are dropped
    logic wr_en;

    assign wr_en = commit_i.valid && (commit_i.prd != '0);

    // Update one edge after the commit record shows up
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en) begin
            regs_q[commit_i.prd] <= commit_i.value;
        end
    end

    // Combinational read
    // Register 0 keeps its reset value of zero
    assign rd_data_o = regs_q[rd_addr_i];

endmodule

// ==== hw/rob.sv ====
`timescale 1ns/1ps

`include "rob_params.svh"

module rob import core_pkg::*, rob_pkg::*; (
    input  logic     clk_i,
    input  logic     reset_i,
    // Dispatch side
    input  alloc_t   alloc_i,
    output rob_idx_t rob_idx_o,
    output logic     alloc_credit_o,
    // Functional unit writebacks
    input  wb_t      wb_alu_i,
    input  wb_t      wb_lsu_i,
    input  wb_t      wb_mul_i,
    // Retire side
    input  logic     retire_credit_i,
    output commit_t  commit_o,
    output logic     empty_o
);

    // Enough bits to count up to the reset credit value
    localparam int CREDIT_W = $clog2(`ROB_COMMIT_CREDITS + 1);

    rob_idx_t head_q;
    rob_idx_t tail_q;

    // Per-entry state and result
    entry_state_e state_q  [`ROB_DEPTH];
    word_t        result_q [`ROB_DEPTH];

    // Commit credits currently held
    logic [CREDIT_W-1:0] credit_q;

    // Writeback ports gathered for looping
    wb_t wb_ports [NUM_WB];

    // Static fields of the head entry
    word_t     head_pc;
    word_t     head_inst;
    reg_addr_t head_prd;

    logic    retire;
    logic    alloc_credit_q;
    commit_t commit_q;

    always_comb begin
        wb_ports[WB_ALU] = wb_alu_i;
        wb_ports[WB_LSU] = wb_lsu_i;
        wb_ports[WB_MUL] = wb_mul_i;
    end

    // Head done and a consumer credit in hand
    assign retire = (state_q[head_q] == ENTRY_DONE) && (credit_q != '0);

    // Entries are contiguous from head, so a free head means empty
    assign empty_o   = (state_q[head_q] == ENTRY_FREE);
    assign rob_idx_o = tail_q;

    // Pointer movement
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            head_q <= '0;
            tail_q <= '0;
        end else begin
            if (alloc_i.valid) begin
                tail_q <= tail_q + 1'b1;
            end
            if (retire) begin
                head_q <= head_q + 1'b1;
            end
        end
    end

    // Entry state transitions
    // Retire, allocate and writeback never touch the same slot in one cycle
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                state_q[i] <= ENTRY_FREE;
            end
        end else begin
            if (retire) begin
                state_q[head_q] <= ENTRY_FREE;
            end
            if (alloc_i.valid) begin
                state_q[tail_q] <= ENTRY_BUSY;
            end
            for (int p = 0; p < NUM_WB; p++) begin
                if (wb_ports[p].valid) begin
                    state_q[wb_ports[p].rob_idx] <= ENTRY_DONE;
                end
            end
        end
    end

    // Result capture, one slot per port and cycle
    always_ff @(posedge clk_i) begin
        for (int p = 0; p < NUM_WB; p++) begin
            if (wb_ports[p].valid) begin
                result_q[wb_ports[p].rob_idx] <= wb_ports[p].value;
            end
        end
    end

    // Commit credit counter
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            credit_q <= CREDIT_W'(`ROB_COMMIT_CREDITS);
        end else begin
            case ({retire_credit_i, retire})
                2'b10:   credit_q <= credit_q + 1'b1;
                2'b01:   credit_q <= credit_q - 1'b1;
                default: credit_q <= credit_q;
            endcase
        end
    end

    // Registered commit record and allocation credit return
    // Payload only loads on retire
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            commit_q.valid <= 1'b0;
            alloc_credit_q <= 1'b0;
        end else begin
            commit_q.valid <= retire;
            alloc_credit_q <= retire;
        end
        if (retire) begin
            commit_q.rob_idx <= head_q;
            commit_q.pc      <= head_pc;
            commit_q.inst    <= head_inst;
            commit_q.prd     <= head_prd;
            commit_q.value   <= result_q[head_q];
        end
    end

    assign commit_o       = commit_q;
    assign alloc_credit_o = alloc_credit_q;

    // Static fields, written at allocation, popped at retire
    rob_fifo #(.WIDTH($bits(word_t))) u_pc_fifo (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .wr_i    (alloc_i.valid),
        .data_i  (alloc_i.pc),
        .pop_i   (retire),
        .data_o  (head_pc)
    );

    rob_fifo #(.WIDTH($bits(word_t))) u_inst_fifo (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .wr_i    (alloc_i.valid),
        .data_i  (alloc_i.inst),
        .pop_i   (retire),
        .data_o  (head_inst)
    );

    rob_fifo #(.WIDTH($bits(reg_addr_t))) u_prd_fifo (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .wr_i    (alloc_i.valid),
        .data_i  (alloc_i.prd),
        .pop_i   (retire),
        .data_o  (head_prd)
    );

endmodule

// ==== hw/rob_fifo.sv ====
`timescale 1ns/1ps

`include "rob_params.svh"

// Circular store for one static entry field
// Runs in lockstep with the buffer pointers
module rob_fifo #(
    parameter int WIDTH = 32
) (
    input  logic             clk_i,
    input  logic             reset_i,
    input  logic             wr_i,
    input  logic [WIDTH-1:0] data_i,
    input  logic             pop_i,
    output logic [WIDTH-1:0] data_o
);

    // Slot storage, no reset needed
    logic [WIDTH-1:0] mem_q [`ROB_DEPTH];

    // Own copies of head and tail
    logic [`ROB_IDX_W-1:0] head_q;
    logic [`ROB_IDX_W-1:0] tail_q;

    // Pointers wrap naturally at ROB_DEPTH
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            head_q <= '0;
            tail_q <= '0;
        end else begin
            if (wr_i) begin
                tail_q <= tail_q + 1'b1;
            end
            if (pop_i) begin
                head_q <= head_q + 1'b1;
            end
        end
    end

    // Write at tail on the allocation edge
    // Never overfills, allocation credits bound the occupancy
    always_ff @(posedge clk_i) begin
        if (wr_i) begin
            mem_q[tail_q] <= data_i;
        end
    end

    // Oldest entry, read combinationally
    assign data_o = mem_q[head_q];

endmodule

// ==== hw/rob_pkg.sv ====
`include "rob_params.svh"

package rob_pkg;

    import core_pkg::*;

    // Buffer entry index
    typedef logic [`ROB_IDX_W-1:0] rob_idx_t;

    // Life cycle of one buffer entry
    // FREE -> BUSY on allocation, BUSY -> DONE on writeback, DONE -> FREE on retire
    typedef enum logic [1:0] {
        ENTRY_FREE = 2'd0,
        ENTRY_BUSY = 2'd1,
        ENTRY_DONE = 2'd2
    } entry_state_e;

    // Dispatch request, one per cycle in program order
    typedef struct packed {
        logic      valid;
        word_t     pc;
        word_t     inst;
        // Destination register
        reg_addr_t prd;
    } alloc_t;

    // Retirement record, one cycle wide
    typedef struct packed {
        logic      valid;
        rob_idx_t  rob_idx;
        word_t     pc;
        word_t     inst;
        reg_addr_t prd;
        // Result written back by the unit
        word_t     value;
    } commit_t;

endpackage

// ==== hw/core_pkg.sv ====
`include "rob_params.svh"

package core_pkg;

    // Data word, also used for pc and instruction word
    typedef logic [`XLEN-1:0] word_t;

    // Architectural register address
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // Buffer slot as seen by the functional units
    // Kept as a plain vector so the units need not know rob_pkg
    typedef logic [`ROB_IDX_W-1:0] wb_idx_t;

    // Result record from one functional unit
    // One of these per writeback port (ALU, LSU, MUL)
    typedef struct packed {
        // Port carries a result this cycle
        logic    valid;
        // Buffer entry that receives the result
        wb_idx_t rob_idx;
        // Destination value
        word_t   value;
    } wb_t;

    // Index of each writeback port in the unit array
    localparam int WB_ALU = 0;
    localparam int WB_LSU = 1;
    localparam int WB_MUL = 2;

    // Number of writeback ports
    localparam int NUM_WB = 3;

endpackage

// ==== hw/rob_params.svh ====
`ifndef ROB_PARAMS_SVH
`define ROB_PARAMS_SVH

// Reorder buffer sizing
// Depth must stay a power of two so the pointers wrap on their own
`define ROB_DEPTH 32
`define ROB_IDX_W 5

// Commit credits held by the buffer right after reset
`define ROB_COMMIT_CREDITS 4

// Architectural integer registers of RV32
`define REG_COUNT 32

// Register address width, follows REG_COUNT
`define REG_ADDR_W 5

// Data path width
`define XLEN 32

`endif
